//--- bench/l2_cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_settings.svh"

module l2_cache_tb;

    localparam int LINE_W      = `L2_LINE_W;
    localparam int SETS        = `L2_SETS;
    localparam int DRIVE_DELAY = 2;
    localparam int RANDOM_REQ  = 200;
    localparam int TOTAL_REQ   = RANDOM_REQ + 16;
    localparam int CYCLE_LIMIT = TOTAL_REQ * (2 * `PMEM_DELAY + 8) + 100;

    logic              clk;
    logic              rst;
    logic              mem_read;
    logic              mem_write;
    l2_pkg::l2_req_t   req;
    logic              mem_resp;
    logic [LINE_W-1:0] mem_rdata;
    logic              pmem_resp;
    logic [LINE_W-1:0] pmem_rdata;
    logic              pmem_read;
    logic              pmem_write;
    l2_pkg::pmem_req_t pmem_req;
    logic              req_active;

    // Memory contents as the CPU sees them
    logic [LINE_W-1:0]    shadow [logic [31:0]];
    // Expected cache state per set
    logic [`L2_TAG_W-1:0] ref_tag [SETS][4];
    logic                 ref_valid [SETS][4];
    logic                 ref_dirty [SETS][4];
    logic [2:0]           ref_lru [SETS];

    logic              exp_hit;
    int                exp_wb_count;
    int                exp_fill_count;
    logic [31:0]       exp_wb_addr;
    logic [31:0]       exp_fill_addr;
    logic [LINE_W-1:0] exp_wb_data;
    logic [LINE_W-1:0] exp_rdata;
    int                wb_count = 0;
    int                fill_count = 0;
    int                errors = 0;
    int                requests = 0;
    int                cycles = 0;
    logic [31:0]       lfsr = 32'h8a22;

    l2_cache dut_i (
        .clk          (clk),
        .rst          (rst),
        .mem_read_i   (mem_read),
        .mem_write_i  (mem_write),
        .req_i        (req),
        .mem_resp_o   (mem_resp),
        .mem_rdata_o  (mem_rdata),
        .pmem_resp_i  (pmem_resp),
        .pmem_rdata_i (pmem_rdata),
        .pmem_read_o  (pmem_read),
        .pmem_write_o (pmem_write),
        .pmem_req_o   (pmem_req)
    );

    pmem_model memory_i (
        .clk     (clk),
        .rst     (rst),
        .read_i  (pmem_read),
        .write_i (pmem_write),
        .req_i   (pmem_req),
        .resp_o  (pmem_resp),
        .rdata_o (pmem_rdata)
    );

    assign req_active = mem_read || mem_write;

    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    // Completed memory accesses within the current request
    always @(posedge clk) begin
        if (!req_active) begin
            wb_count   <= 0;
            fill_count <= 0;
        end else begin
            if (pmem_write && pmem_resp) begin
                wb_count <= wb_count + 1;
            end
            if (pmem_read && pmem_resp) begin
                fill_count <= fill_count + 1;
            end
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [LINE_W-1:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[LINE_W-2:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] line_of(input logic [31:0] addr);
        return {addr[31:`L2_OFFSET_W], {`L2_OFFSET_W{1'b0}}};
    endfunction

    function automatic logic [LINE_W-1:0] memory_line(input logic [31:0] line_addr);
        logic [LINE_W-1:0] line;
        if (shadow.exists(line_addr)) begin
            line = shadow[line_addr];
        end else begin
            for (int i = 0; i < LINE_W / 32; i++) begin
                line[32*i +: 32] = (line_addr + 32'(4 * i)) ^ 32'h5a5a0000;
            end
        end
        return line;
    endfunction

    // Work out hit, victim and memory traffic, then update the expected state
    task automatic predict_access(input logic is_write, input logic [31:0] addr);
        logic [`L2_SET_W-1:0] set;
        logic [`L2_TAG_W-1:0] tag;
        logic [2:0]           tree;
        int                   way;
        set            = addr[`L2_OFFSET_W +: `L2_SET_W];
        tag            = addr[31 -: `L2_TAG_W];
        way            = -1;
        exp_wb_count   = 0;
        exp_fill_count = 0;
        exp_fill_addr  = line_of(addr);
        exp_rdata      = memory_line(line_of(addr));
        for (int w = 0; w < 4; w++) begin
            if (ref_valid[set][w] && ref_tag[set][w] == tag) begin
                way = w;
            end
        end
        exp_hit = (way >= 0);
        if (way < 0) begin
            tree = ref_lru[set];
            if (tree[0]) begin
                way = tree[1] ? 0 : 1;
            end else begin
                way = tree[2] ? 2 : 3;
            end
            if (ref_valid[set][way] && ref_dirty[set][way]) begin
                exp_wb_count = 1;
                exp_wb_addr  = {ref_tag[set][way], set, {`L2_OFFSET_W{1'b0}}};
                exp_wb_data  = memory_line(exp_wb_addr);
            end
            exp_fill_count       = 1;
            ref_tag[set][way]   = tag;
            ref_valid[set][way] = 1'b1;
            ref_dirty[set][way] = 1'b0;
        end
        // The final hit points the tree away from the way
        case (way)
            0: ref_lru[set] = {ref_lru[set][2], 2'b00};
            1: ref_lru[set] = {ref_lru[set][2], 2'b10};
            2: ref_lru[set] = {1'b0, ref_lru[set][1], 1'b1};
            default: ref_lru[set] = {1'b1, ref_lru[set][1], 1'b1};
        endcase
        if (is_write) begin
            ref_dirty[set][way] = 1'b1;
        end
    endtask

    task automatic issue_request(input logic is_write, input logic [31:0] addr,
                                 input logic [LINE_W-1:0] wdata,
                                 input logic [`L2_MASK_W-1:0] mbe);
        logic              done;
        logic [31:0]       line;
        logic [LINE_W-1:0] merged;
        @(posedge clk);
        #(DRIVE_DELAY);
        predict_access(is_write, addr);
        req.addr  = addr;
        req.wdata = wdata;
        req.mbe   = mbe;
        mem_read  = !is_write;
        mem_write = is_write;
        done      = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = mem_resp;
        end
        @(posedge clk);
        #(DRIVE_DELAY);
        mem_read  = 1'b0;
        mem_write = 1'b0;
        if (is_write) begin
            line   = line_of(addr);
            merged = memory_line(line);
            for (int b = 0; b < `L2_MASK_W; b++) begin
                if (mbe[b]) begin
                    merged[8*b +: 8] = wdata[8*b +: 8];
                end
            end
            shadow[line] = merged;
        end
        requests++;
    endtask

    // Two sets and eight tags, so evictions are frequent
    task automatic issue_random_request();
        logic [LINE_W-1:0] bits;
        logic [LINE_W-1:0] wdata;
        logic [2:0]        tag_sel;
        logic              is_write;
        logic              set_sel;
        take_bits(1, bits);
        is_write = bits[0];
        take_bits(3, bits);
        tag_sel = bits[2:0];
        take_bits(1, bits);
        set_sel = bits[0];
        take_bits(LINE_W, wdata);
        take_bits(`L2_MASK_W, bits);
        issue_request(is_write, 32'h0008_0000 | {21'd0, tag_sel, 2'b00, set_sel, 5'd0},
                      wdata, bits[`L2_MASK_W-1:0]);
    endtask

    task automatic report_test(input string name);
        $display("test %s finished: %0d requests so far, %0d failed checks so far",
                 name, requests, errors);
    endtask

    a_quiet_without_request: assert property (@(posedge clk) disable iff (rst)
        !req_active |-> !(mem_resp || pmem_read || pmem_write))
        else begin
            $display("CHECK FAILED mem_resp_o/pmem_read_o/pmem_write_o: got %h %h %h expected 0 0 0",
                     $sampled(mem_resp), $sampled(pmem_read), $sampled(pmem_write));
            errors++;
        end

    a_strobes_apart: assert property (@(posedge clk) disable iff (rst)
        !(pmem_read && pmem_write))
        else begin
            $display("memory read and write strobes are high in the same cycle");
            errors++;
        end

    a_hit_latency: assert property (@(posedge clk) disable iff (rst)
        $rose(req_active) && exp_hit |=> mem_resp)
        else begin
            $display("CHECK FAILED mem_resp_o: got %h expected %h one cycle after a hit request",
                     $sampled(mem_resp), 1'b1);
            errors++;
        end

    a_miss_not_early: assert property (@(posedge clk) disable iff (rst)
        $rose(req_active) && !exp_hit |=> !mem_resp)
        else begin
            $display("CHECK FAILED mem_resp_o: got %h expected %h in hit check of a miss",
                     $sampled(mem_resp), 1'b0);
            errors++;
        end

    a_hit_no_strobe: assert property (@(posedge clk) disable iff (rst)
        req_active && exp_hit |-> !pmem_read && !pmem_write)
        else begin
            $display("memory strobe raised while serving a hit");
            errors++;
        end

    a_read_data: assert property (@(posedge clk) disable iff (rst)
        mem_resp && mem_read |-> mem_rdata == exp_rdata)
        else begin
            $display("CHECK FAILED mem_rdata_o: got %h expected %h", $sampled(mem_rdata), exp_rdata);
            errors++;
        end

    a_fill_addr: assert property (@(posedge clk) disable iff (rst)
        pmem_read |-> pmem_req.addr == exp_fill_addr)
        else begin
            $display("CHECK FAILED pmem_req_o.addr: got %h expected %h on fill",
                     $sampled(pmem_req.addr), exp_fill_addr);
            errors++;
        end

    a_wb_expected: assert property (@(posedge clk) disable iff (rst)
        pmem_write |-> exp_wb_count == 1)
        else begin
            $display("write back issued although the victim is not valid and dirty");
            errors++;
        end

    a_wb_line: assert property (@(posedge clk) disable iff (rst)
        pmem_write |-> pmem_req.addr == exp_wb_addr && pmem_req.wdata == exp_wb_data)
        else begin
            $display("CHECK FAILED pmem_req_o: got addr %h data %h expected addr %h data %h",
                     $sampled(pmem_req.addr), $sampled(pmem_req.wdata), exp_wb_addr, exp_wb_data);
            errors++;
        end

    a_wb_then_fill: assert property (@(posedge clk) disable iff (rst)
        pmem_write && pmem_resp |=> pmem_read)
        else begin
            $display("write back was not followed directly by a fill");
            errors++;
        end

    a_access_counts: assert property (@(posedge clk) disable iff (rst)
        mem_resp |-> wb_count == exp_wb_count && fill_count == exp_fill_count)
        else begin
            $display("CHECK FAILED write backs/fills: got %h %h expected %h %h",
                     $sampled(wb_count), $sampled(fill_count), exp_wb_count, exp_fill_count);
            errors++;
        end

    initial begin
        logic [LINE_W-1:0] wdata;
        rst       = 1'b1;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        req       = '0;
        exp_hit   = 1'b0;
        for (int s = 0; s < SETS; s++) begin
            ref_lru[s] = 3'b000;
            for (int w = 0; w < 4; w++) begin
                ref_tag[s][w]   = '0;
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
            end
        end
        repeat (3) @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b0;

        // Ports must stay quiet with no request
        repeat (8) @(posedge clk);
        report_test("reset_idle");

        issue_request(1'b0, 32'h0000_1040, '0, '0);
        report_test("read_miss");

        take_bits(LINE_W, wdata);
        issue_request(1'b0, 32'h0000_1040, '0, '0);
        issue_request(1'b1, 32'h0000_1044, wdata, 32'h0f0f_00ff);
        issue_request(1'b0, 32'h0000_1040, '0, '0);
        report_test("resident_hits");

        // Six dirty tags in set 5 overflow its four ways
        for (int t = 0; t < 6; t++) begin
            take_bits(LINE_W, wdata);
            issue_request(1'b1, {16'h0010, 8'(t), 3'd5, 5'd0}, wdata, '1);
        end
        for (int t = 0; t < 6; t++) begin
            issue_request(1'b0, {16'h0010, 8'(t), 3'd5, 5'd0}, '0, '0);
        end
        report_test("eviction");

        for (int i = 0; i < RANDOM_REQ; i++) begin
            issue_random_request();
        end
        report_test("random_mix");

        repeat (2) @(posedge clk);
        $display("requests: %0d, failed checks: %0d", requests, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/pmem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_settings.svh"

module pmem_model (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  read_i,
    input  wire logic                  write_i,
    input  wire l2_pkg::pmem_req_t     req_i,
    output logic                       resp_o,
    output logic [`L2_LINE_W-1:0]      rdata_o
);

    // Lines written back so far, keyed by line address
    logic [`L2_LINE_W-1:0] lines [logic [31:0]];
    int                    count;

    // Each word holds its own byte address, scrambled
    function automatic logic [`L2_LINE_W-1:0] initial_content(input logic [31:0] line_addr);
        logic [`L2_LINE_W-1:0] line;
        for (int i = 0; i < `L2_LINE_W / 32; i++) begin
            line[32*i +: 32] = (line_addr + 32'(4 * i)) ^ 32'h5a5a0000;
        end
        return line;
    endfunction

    function automatic logic [`L2_LINE_W-1:0] stored_line(input logic [31:0] line_addr);
        if (lines.exists(line_addr)) begin
            return lines[line_addr];
        end
        return initial_content(line_addr);
    endfunction

    // Count cycles while a strobe is up, answer after the fixed delay
    always @(posedge clk) begin
        if (rst) begin
            count   <= 0;
            resp_o  <= 1'b0;
            rdata_o <= '0;
        end else begin
            resp_o <= 1'b0;
            if ((read_i || write_i) && !resp_o) begin
                if (count == `PMEM_DELAY - 1) begin
                    count  <= 0;
                    resp_o <= 1'b1;
                    if (write_i) begin
                        lines[req_i.addr] = req_i.wdata;
                    end else begin
                        rdata_o <= stored_line(req_i.addr);
                    end
                end else begin
                    count <= count + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/l2_cache.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_settings.svh"

module l2_cache (
    input  wire logic                  clk,
    input  wire logic                  rst,
    // CPU side
    input  wire logic                  mem_read_i,
    input  wire logic                  mem_write_i,
    input  wire l2_pkg::l2_req_t       req_i,
    output logic                       mem_resp_o,
    output logic [`L2_LINE_W-1:0]      mem_rdata_o,
    // Memory side
    input  wire logic                  pmem_resp_i,
    input  wire logic [`L2_LINE_W-1:0] pmem_rdata_i,
    output logic                       pmem_read_o,
    output logic                       pmem_write_o,
    output l2_pkg::pmem_req_t          pmem_req_o
);

    l2_pkg::dimux_sel_t                dimux_sel;
    l2_pkg::domux_sel_t                domux_sel;
    l2_pkg::addrmux_sel_t              addrmux_sel;
    l2_pkg::wemux_sel_t [`L2_WAYS-1:0] wemux_sel;
    logic [`L2_WAYS-1:0]               valid_load;
    logic [`L2_WAYS-1:0]               dirty_load;
    logic [`L2_WAYS-1:0]               tag_load;
    logic [`L2_WAYS-1:0]               valid_wr;
    logic [`L2_WAYS-1:0]               dirty_wr;
    logic [`L2_WAYS-1:0]               hit;
    logic [`L2_WAYS-1:0]               valid;
    logic [`L2_WAYS-1:0]               dirty;
    logic [2:0]                        lru;
    logic                              lru_load;
    logic [1:0]                        lru_way;

    l2_control control_i (
        .clk           (clk),
        .rst           (rst),
        .lru_i         (lru),
        .valid_i       (valid),
        .dirty_i       (dirty),
        .hit_i         (hit),
        .dimux_sel_o   (dimux_sel),
        .domux_sel_o   (domux_sel),
        .addrmux_sel_o (addrmux_sel),
        .wemux_sel_o   (wemux_sel),
        .valid_load_o  (valid_load),
        .dirty_load_o  (dirty_load),
        .tag_load_o    (tag_load),
        .valid_o       (valid_wr),
        .dirty_o       (dirty_wr),
        .lru_load_o    (lru_load),
        .lru_way_o     (lru_way),
        .mem_read_i    (mem_read_i),
        .mem_write_i   (mem_write_i),
        .mem_resp_o    (mem_resp_o),
        .pmem_resp_i   (pmem_resp_i),
        .pmem_read_o   (pmem_read_o),
        .pmem_write_o  (pmem_write_o)
    );

    l2_datapath datapath_i (
        .clk           (clk),
        .rst           (rst),
        .req_i         (req_i),
        .pmem_rdata_i  (pmem_rdata_i),
        .dimux_sel_i   (dimux_sel),
        .domux_sel_i   (domux_sel),
        .addrmux_sel_i (addrmux_sel),
        .wemux_sel_i   (wemux_sel),
        .valid_load_i  (valid_load),
        .dirty_load_i  (dirty_load),
        .tag_load_i    (tag_load),
        .valid_i       (valid_wr),
        .dirty_i       (dirty_wr),
        .hit_o         (hit),
        .valid_o       (valid),
        .dirty_o       (dirty),
        .mem_rdata_o   (mem_rdata_o),
        .pmem_req_o    (pmem_req_o)
    );

    l2_plru plru_i (
        .clk     (clk),
        .rst     (rst),
        .index_i (req_i.addr[`L2_OFFSET_W +: `L2_SET_W]),
        .load_i  (lru_load),
        .way_i   (lru_way),
        .lru_o   (lru)
    );

endmodule

`default_nettype wire

//--- hdl/l2_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_settings.svh"

module l2_control (
    input  wire logic                      clk,
    input  wire logic                      rst,
    // From PLRU and datapath
    input  wire logic [2:0]                lru_i,
    input  wire logic [`L2_WAYS-1:0]       valid_i,
    input  wire logic [`L2_WAYS-1:0]       dirty_i,
    input  wire logic [`L2_WAYS-1:0]       hit_i,
    // To datapath
    output l2_pkg::dimux_sel_t             dimux_sel_o,
    output l2_pkg::domux_sel_t             domux_sel_o,
    output l2_pkg::addrmux_sel_t           addrmux_sel_o,
    output l2_pkg::wemux_sel_t [`L2_WAYS-1:0] wemux_sel_o,
    output logic [`L2_WAYS-1:0]            valid_load_o,
    output logic [`L2_WAYS-1:0]            dirty_load_o,
    output logic [`L2_WAYS-1:0]            tag_load_o,
    output logic [`L2_WAYS-1:0]            valid_o,
    output logic [`L2_WAYS-1:0]            dirty_o,
    // To PLRU
    output logic                           lru_load_o,
    output logic [1:0]                     lru_way_o,
    // CPU side
    input  wire logic                      mem_read_i,
    input  wire logic                      mem_write_i,
    output logic                           mem_resp_o,
    // Memory side
    input  wire logic                      pmem_resp_i,
    output logic                           pmem_read_o,
    output logic                           pmem_write_o
);

    typedef enum logic [1:0] {
        st_idle,
        st_hit_check,
        st_write_back,
        st_read_back
    } state_t;

    state_t     state;
    state_t     next_state;
    logic [1:0] hit_way;
    logic [1:0] victim_way;

    // One-hot hit to way number
    always_comb begin
        case (hit_i)
            4'b0010: hit_way = 2'd1;
            4'b0100: hit_way = 2'd2;
            4'b1000: hit_way = 2'd3;
            default: hit_way = 2'd0;
        endcase
    end

    // Walk the tree; bit 0 picks the pair, bit 1 or 2 the way in it
    always_comb begin
        if (lru_i[0]) begin
            victim_way = lru_i[1] ? 2'd0 : 2'd1;
        end else begin
            victim_way = lru_i[2] ? 2'd2 : 2'd3;
        end
    end

    assign lru_way_o = hit_way;

    always_comb begin
        dimux_sel_o   = l2_pkg::dimux_cpu_wdata;
        domux_sel_o   = l2_pkg::domux_way0;
        addrmux_sel_o = l2_pkg::addrmux_cpu;
        for (int w = 0; w < `L2_WAYS; w++) begin
            wemux_sel_o[w] = l2_pkg::wemux_none;
        end
        valid_load_o = '0;
        dirty_load_o = '0;
        tag_load_o   = '0;
        valid_o      = '0;
        dirty_o      = '0;
        lru_load_o   = 1'b0;
        mem_resp_o   = 1'b0;
        pmem_read_o  = 1'b0;
        pmem_write_o = 1'b0;

        case (state)
            st_hit_check: begin
                if (hit_i != '0) begin
                    mem_resp_o  = 1'b1;
                    lru_load_o  = 1'b1;
                    domux_sel_o = l2_pkg::domux_sel_t'(hit_way);
                    if (mem_write_i) begin
                        // Merge masked bytes and mark the line dirty
                        wemux_sel_o[hit_way]  = l2_pkg::wemux_mask;
                        dirty_load_o[hit_way] = 1'b1;
                        dirty_o[hit_way]      = 1'b1;
                    end
                end
            end
            st_write_back: begin
                pmem_write_o  = 1'b1;
                domux_sel_o   = l2_pkg::domux_sel_t'(victim_way);
                addrmux_sel_o = l2_pkg::addrmux_sel_t'({1'b1, victim_way});
            end
            st_read_back: begin
                pmem_read_o = 1'b1;
                if (pmem_resp_i) begin
                    // Fill the victim, valid and clean
                    dimux_sel_o              = l2_pkg::dimux_pmem_rdata;
                    wemux_sel_o[victim_way]  = l2_pkg::wemux_all;
                    valid_load_o[victim_way] = 1'b1;
                    dirty_load_o[victim_way] = 1'b1;
                    tag_load_o[victim_way]   = 1'b1;
                    valid_o[victim_way]      = 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (mem_read_i || mem_write_i) begin
                    next_state = st_hit_check;
                end
            end
            st_hit_check: begin
                if (hit_i != '0) begin
                    next_state = st_idle;
                end else if (valid_i[victim_way] && dirty_i[victim_way]) begin
                    next_state = st_write_back;
                end else begin
                    next_state = st_read_back;
                end
            end
            st_write_back: begin
                if (pmem_resp_i) begin
                    next_state = st_read_back;
                end
            end
            st_read_back: begin
                if (pmem_resp_i) begin
                    next_state = st_idle;
                end
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    a_strobes_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(pmem_read_o && pmem_write_o))
        else $error("pmem_read_o and pmem_write_o high together");

    a_resp_needs_req: assert property (@(posedge clk) disable iff (rst)
        mem_resp_o |-> (mem_read_i || mem_write_i))
        else $error("mem_resp_o without a request");

    a_hit_onehot: assert property (@(posedge clk) disable iff (rst)
        (state == st_hit_check) |-> $onehot0(hit_i))
        else $error("hit_i not one-hot in hit check: %h", hit_i);

endmodule

`default_nettype wire

//--- hdl/l2_datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_settings.svh"

module l2_datapath (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire l2_pkg::l2_req_t              req_i,
    input  wire logic [`L2_LINE_W-1:0]        pmem_rdata_i,
    // Selects and loads from control
    input  wire l2_pkg::dimux_sel_t           dimux_sel_i,
    input  wire l2_pkg::domux_sel_t           domux_sel_i,
    input  wire l2_pkg::addrmux_sel_t         addrmux_sel_i,
    input  wire l2_pkg::wemux_sel_t [`L2_WAYS-1:0] wemux_sel_i,
    input  wire logic [`L2_WAYS-1:0]          valid_load_i,
    input  wire logic [`L2_WAYS-1:0]          dirty_load_i,
    input  wire logic [`L2_WAYS-1:0]          tag_load_i,
    input  wire logic [`L2_WAYS-1:0]          valid_i,
    input  wire logic [`L2_WAYS-1:0]          dirty_i,
    // Status of the indexed set
    output logic [`L2_WAYS-1:0]               hit_o,
    output logic [`L2_WAYS-1:0]               valid_o,
    output logic [`L2_WAYS-1:0]               dirty_o,
    output logic [`L2_LINE_W-1:0]             mem_rdata_o,
    output l2_pkg::pmem_req_t                 pmem_req_o
);

    logic [`L2_SET_W-1:0]  index;
    logic [`L2_TAG_W-1:0]  tag;
    logic [`L2_LINE_W-1:0] data_in;
    logic [`L2_LINE_W-1:0] out_line;
    logic [`L2_TAG_W-1:0]  line_tag;
    logic [`L2_LINE_W-1:0] way_data [`L2_WAYS];
    logic [`L2_TAG_W-1:0]  way_tag [`L2_WAYS];

    assign index = req_i.addr[`L2_OFFSET_W +: `L2_SET_W];
    assign tag   = req_i.addr[`L2_ADDR_W-1 -: `L2_TAG_W];

    assign data_in = (dimux_sel_i == l2_pkg::dimux_pmem_rdata) ? pmem_rdata_i : req_i.wdata;

    for (genvar w = 0; w < `L2_WAYS; w++) begin : g_way
        logic [`L2_LINE_W-1:0] data_q [`L2_SETS];
        logic [`L2_TAG_W-1:0]  tag_q [`L2_SETS];
        logic [`L2_SETS-1:0]   valid_q;
        logic [`L2_SETS-1:0]   dirty_q;
        logic [`L2_MASK_W-1:0] byte_en;

        always_comb begin
            case (wemux_sel_i[w])
                l2_pkg::wemux_mask: byte_en = req_i.mbe;
                l2_pkg::wemux_all:  byte_en = '1;
                default:            byte_en = '0;
            endcase
        end

        // Line and tag storage
        always_ff @(posedge clk) begin
            for (int b = 0; b < `L2_MASK_W; b++) begin
                if (byte_en[b]) begin
                    data_q[index][8*b +: 8] <= data_in[8*b +: 8];
                end
            end
            if (tag_load_i[w]) begin
                tag_q[index] <= tag;
            end
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                valid_q <= '0;
                dirty_q <= '0;
            end else begin
                if (valid_load_i[w]) begin
                    valid_q[index] <= valid_i[w];
                end
                if (dirty_load_i[w]) begin
                    dirty_q[index] <= dirty_i[w];
                end
            end
        end

        assign way_data[w] = data_q[index];
        assign way_tag[w]  = tag_q[index];
        assign valid_o[w]  = valid_q[index];
        assign dirty_o[w]  = dirty_q[index];
        assign hit_o[w]    = valid_q[index] && (tag_q[index] == tag);
    end

    assign out_line    = way_data[domux_sel_i];
    assign mem_rdata_o = out_line;

    // Stored tag for write back, request tag for the fill
    always_comb begin
        case (addrmux_sel_i)
            l2_pkg::addrmux_tag0: line_tag = way_tag[0];
            l2_pkg::addrmux_tag1: line_tag = way_tag[1];
            l2_pkg::addrmux_tag2: line_tag = way_tag[2];
            l2_pkg::addrmux_tag3: line_tag = way_tag[3];
            default:              line_tag = tag;
        endcase
    end

    assign pmem_req_o.addr  = {line_tag, index, {`L2_OFFSET_W{1'b0}}};
    assign pmem_req_o.wdata = out_line;

    // Duplicate tags in one set would mean a broken fill
    a_single_hit: assert property (@(posedge clk) disable iff (rst)
        $onehot0(hit_o))
        else $error("more than one way hits: %h", hit_o);

endmodule

`default_nettype wire

//--- hdl/l2_pkg.sv
`default_nettype none

`include "l2_settings.svh"

package l2_pkg;

    // Source of the line written into a way
    typedef enum logic {
        dimux_cpu_wdata  = 1'b0,
        dimux_pmem_rdata = 1'b1
    } dimux_sel_t;

    // Way whose line goes to the CPU and to write back
    typedef enum logic [1:0] {
        domux_way0 = 2'd0,
        domux_way1 = 2'd1,
        domux_way2 = 2'd2,
        domux_way3 = 2'd3
    } domux_sel_t;

    // Memory address source; upper bit set means a stored tag
    typedef enum logic [2:0] {
        addrmux_cpu  = 3'b000,
        addrmux_tag0 = 3'b100,
        addrmux_tag1 = 3'b101,
        addrmux_tag2 = 3'b110,
        addrmux_tag3 = 3'b111
    } addrmux_sel_t;

    // Byte write enable source for one way
    typedef enum logic [1:0] {
        wemux_none = 2'd0,
        wemux_mask = 2'd1,
        wemux_all  = 2'd2
    } wemux_sel_t;

    typedef struct packed {
        logic [`L2_ADDR_W-1:0] addr;
        logic [`L2_LINE_W-1:0] wdata;
        logic [`L2_MASK_W-1:0] mbe;
    } l2_req_t;

    typedef struct packed {
        logic [`L2_ADDR_W-1:0] addr;
        logic [`L2_LINE_W-1:0] wdata;
    } pmem_req_t;

endpackage

`default_nettype wire

//--- hdl/l2_plru.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_settings.svh"

module l2_plru (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic [`L2_SET_W-1:0] index_i,
    input  wire logic                 load_i,
    input  wire logic [1:0]           way_i,
    output logic [2:0]                lru_o
);

    logic [`L2_SETS-1:0][2:0] lru_q;
    logic [2:0]               lru_next;

    assign lru_o = lru_q[index_i];

    // Point the tree away from the accessed way
    always_comb begin
        lru_next    = lru_o;
        lru_next[0] = way_i[1];
        if (way_i[1]) begin
            // Ways 2 and 3 live under bit 2
            lru_next[2] = way_i[0];
        end else begin
            lru_next[1] = way_i[0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lru_q <= '0;
        end else if (load_i) begin
            lru_q[index_i] <= lru_next;
        end
    end

endmodule

`default_nettype wire

//--- include/l2_settings.svh
`ifndef L2_SETTINGS_SVH
`define L2_SETTINGS_SVH

// Byte address width on both ports
`define L2_ADDR_W 32

// One cache line, also the memory transfer size
`define L2_LINE_W 256
`define L2_MASK_W (`L2_LINE_W / 8)

// Address split into tag, index and byte offset
`define L2_OFFSET_W 5
`define L2_SET_W 3
`define L2_SETS (1 << `L2_SET_W)
`define L2_TAG_W (`L2_ADDR_W - `L2_SET_W - `L2_OFFSET_W)

// Tied to the 3-bit PLRU tree
`define L2_WAYS 4

// Memory model response delay in cycles
`define PMEM_DELAY 6

`endif

//--- run.sh
#!/bin/sh
# Build and run the L2 cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module l2_cache_tb --Mdir obj_dir -f verilog.f

./obj_dir/Vl2_cache_tb > sim.log
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
exit 0

//--- verilog.f
+incdir+include
hdl/l2_pkg.sv
hdl/l2_plru.sv
hdl/l2_control.sv
hdl/l2_datapath.sv
hdl/l2_cache.sv
bench/pmem_model.sv
bench/l2_cache_tb.sv
